// ==== all.f ====
csr_pkg.sv
csr_commit_ctrl.sv
csr_trap_regs.sv
csr_status_unit.sv
csr_count_scratch.sv
csr_read_port.sv
sup_csr_file.sv
sup_csr_file_chk.sv
tb_sup_csr_file.sv

// ==== csr_commit_ctrl.sv ====
/*
  write buffer of the CSR file
  only one CSR instruction is in flight, so one entry is enough
  commit leaves the entry valid, a second commit writes the same value again
  unmapped addresses produce no strobe and the write is lost
*/
`timescale 1ns/1ps

module csr_commit_ctrl
  import csr_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        flush_i,
  input  logic        wr_en_i,
  input  csr_addr_t   wr_addr_i,
  input  csr_data_t   wr_data_i,
  input  logic        commit_i,
  output csr_wr_sel_t wr_sel_o
);

  csr_addr_t buf_addr;
  csr_data_t buf_data;
  logic      buf_valid;

  // payload of the buffered write
  always_ff @(posedge clk)
  begin
    if (wr_en_i)
    begin
      buf_addr <= wr_addr_i;
      buf_data <= wr_data_i;
    end
  end

  // a new write wins over a flush in the same cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      buf_valid <= 1'b0;
    end
    else if (wr_en_i)
    begin
      buf_valid <= 1'b1;
    end
    else if (flush_i)
    begin
      buf_valid <= 1'b0;
    end
  end

  // one strobe for the buffered address at commit
  always_comb
  begin
    wr_sel_o      = '0;
    wr_sel_o.data = buf_data;
    if (commit_i && buf_valid)
    begin
      case (buf_addr)
        ADDR_SUP0:     wr_sel_o.sup0     = 1'b1;
        ADDR_SUP1:     wr_sel_o.sup1     = 1'b1;
        ADDR_EPC:      wr_sel_o.epc      = 1'b1;
        ADDR_BADVADDR: wr_sel_o.badvaddr = 1'b1;
        ADDR_COUNT:    wr_sel_o.count    = 1'b1;
        ADDR_EVEC:     wr_sel_o.evec     = 1'b1;
        ADDR_CAUSE:    wr_sel_o.cause    = 1'b1;
        ADDR_STATUS:   wr_sel_o.status   = 1'b1;
        default:       wr_sel_o.data     = buf_data;
      endcase
    end
  end

endmodule

// ==== csr_count_scratch.sv ====
/*
  commit counter and the two supervisor scratch registers
  count adds the retired instructions, plus one for an excepting one
  a committed write to count replaces that cycle's increment
*/
`timescale 1ns/1ps

module csr_count_scratch
  import csr_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  csr_wr_sel_t wr_sel_i,
  input  commit_cnt_t total_commit_i,
  input  exc_info_t   exc_i,
  output csr_data_t   count_o,
  output csr_data_t   sup0_o,
  output csr_data_t   sup1_o
);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count_o <= '0;
      sup0_o  <= '0;
      sup1_o  <= '0;
    end
    else
    begin
      if (wr_sel_i.count)
      begin
        count_o <= wr_sel_i.data;
      end
      else
      begin
        count_o <= count_o + csr_data_t'(total_commit_i) + csr_data_t'(exc_i.valid);
      end
      // scratch registers only change by writes
      if (wr_sel_i.sup0)
      begin
        sup0_o <= wr_sel_i.data;
      end
      if (wr_sel_i.sup1)
      begin
        sup1_o <= wr_sel_i.data;
      end
    end
  end

endmodule

// ==== csr_input.txt ====
// op addr data aux expected, all hex; op 3 uses addr as the cause code
// op 0 read, 1 write+commit, 2 write+flush+commit, 3 exception, 4 sret, 5 commit-count, 6 irq, 7 read-checkpoint
0 500 0000000000000000 0000000000000000 0000000000000000
0 501 0000000000000000 0000000000000000 0000000000000000
0 502 0000000000000000 0000000000000000 0000000000000000
0 503 0000000000000000 0000000000000000 0000000000000000
0 506 0000000000000000 0000000000000000 0000000000000000
0 509 0000000000000000 0000000000000000 0000000000000000
0 50a 0000000000000000 0000000000000000 0000000000000061
0 305 0000000000000000 0000000000000000 0000000000000000
1 500 0123456789abcdef 0000000000000000 0123456789abcdef
1 501 deadbeefcafef00d 0000000000000000 deadbeefcafef00d
1 305 0000000080000100 0000000000000000 0000000080000100
2 500 ffffffffffffffff 0000000000000000 0123456789abcdef
1 7c0 0000000000001234 0000000000000000 0000000000000000
3 005 0000000080001000 00000000c0000008 00000000c0000008
3 006 0000000080001004 00000000c0000011 00000000c0000011
3 001 0000000080002000 0000000000000000 0000000080002000
3 002 0000000080003000 0000000000000000 0000000080002000
5 506 0000000000000003 0000000000000000 0000000000000007
1 506 0000000000000100 0000000000000000 0000000000000100
1 50a 000000000000000a 0000000000000000 000000000000000a
4 50a 0000000000000000 0000000000000000 000000000000000f
1 50a ffffffffffffffff 0000000000000000 0000000000ff01ff
6 50a 0000000000000010 0000000010ff01ff 0000000000000001
1 50a 00000000000000ff 0000000000000000 00000000100000ff
6 50a 0000000000000010 00000000100000ff 0000000000000000
6 50a 0000000000000000 00000000000000ff 0000000000000000
2 500 0000000000005555 0000000000000000 0123456789abcdef
7 506 0000000000000002 0000000000000000 0000000000000001
7 500 0000000000000003 0000000000000000 0000000000000000
7 7c0 0000000000000001 0000000000000000 0000000000000000

// ==== csr_pkg.sv ====
/*
  shared types and constants of the supervisor CSR file
  CSR width is fixed at 64 bits, no module supports another width
  status layout is the older supervisor one: S, PS, EI, PEI, IM and IP
  IP is loaded from the interrupt lines every cycle and is never written
*/
package csr_pkg;

  // one CSR value and one CSR address
  typedef logic [63:0] csr_data_t;
  typedef logic [11:0] csr_addr_t;
  // instructions retired in one cycle
  typedef logic [2:0]  commit_cnt_t;
  typedef logic [3:0]  exc_cause_t;
  typedef logic [7:0]  irq_vec_t;

  // kept registers, everything else reads as zero
  localparam csr_addr_t ADDR_SUP0     = 12'h500;
  localparam csr_addr_t ADDR_SUP1     = 12'h501;
  localparam csr_addr_t ADDR_EPC      = 12'h502;
  localparam csr_addr_t ADDR_BADVADDR = 12'h503;
  localparam csr_addr_t ADDR_COUNT    = 12'h506;
  localparam csr_addr_t ADDR_CAUSE    = 12'h509;
  localparam csr_addr_t ADDR_STATUS   = 12'h50a;
  localparam csr_addr_t ADDR_EVEC     = 12'h305;

  // causes that carry a bad address
  localparam exc_cause_t CAUSE_MISALIGNED_FETCH = 4'd0;
  localparam exc_cause_t CAUSE_FAULT_FETCH      = 4'd1;
  localparam exc_cause_t CAUSE_MISALIGNED_LOAD  = 4'd4;
  localparam exc_cause_t CAUSE_FAULT_LOAD       = 4'd5;
  localparam exc_cause_t CAUSE_MISALIGNED_STORE = 4'd6;
  localparam exc_cause_t CAUSE_FAULT_STORE      = 4'd7;

  // status bit positions
  localparam int SR_S      = 0;
  localparam int SR_PS     = 1;
  localparam int SR_EI     = 2;
  localparam int SR_PEI    = 3;
  localparam int SR_U64    = 5;
  localparam int SR_S64    = 6;
  localparam int SR_IM_LSB = 16;
  localparam int SR_IM_MSB = 23;
  localparam int SR_IP_LSB = 24;
  localparam int SR_IP_MSB = 31;

  // supervisor mode, 64-bit user and supervisor
  localparam csr_data_t STATUS_RESET =
    (64'd1 << SR_S) | (64'd1 << SR_U64) | (64'd1 << SR_S64);
  // bits 8..0 and the IM field, IP is excluded
  localparam csr_data_t STATUS_WR_MASK = 64'h0000_0000_00ff_01ff;

  // exception reported by retire
  typedef struct packed {
    logic       valid;
    csr_data_t  pc;
    exc_cause_t cause;
    csr_data_t  ld_addr;
    csr_data_t  st_addr;
  } exc_info_t;

  // one strobe per kept register, plus the committed data
  typedef struct packed {
    logic      sup0;
    logic      sup1;
    logic      epc;
    logic      badvaddr;
    logic      count;
    logic      evec;
    logic      cause;
    logic      status;
    csr_data_t data;
  } csr_wr_sel_t;

  // live values of all kept registers
  typedef struct packed {
    csr_data_t sup0;
    csr_data_t sup1;
    csr_data_t epc;
    csr_data_t badvaddr;
    csr_data_t count;
    csr_data_t evec;
    csr_data_t cause;
    csr_data_t status;
  } csr_state_t;

endpackage

// ==== csr_read_port.sv ====
/*
  read multiplexer and atomic-read check
  read data is combinational from rd_addr_i, rd_en_i only arms the checkpoint
  the checkpoint is dropped by flush_i or commit_i, a new read wins over both
  unmapped addresses read zero and never flag a violation
*/
`timescale 1ns/1ps

module csr_read_port
  import csr_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       flush_i,
  input  logic       commit_i,
  input  logic       rd_en_i,
  input  csr_addr_t  rd_addr_i,
  input  csr_state_t state_i,
  output csr_data_t  rd_data_o,
  output logic       atomic_vio_o
);

  csr_addr_t chk_addr;
  csr_data_t chk_data;
  logic      chk_valid;
  csr_data_t chk_live;

  // value of one register, zero when unmapped
  function automatic csr_data_t csr_select(input csr_addr_t addr, input csr_state_t st);
    csr_data_t val;
    case (addr)
      ADDR_SUP0:     val = st.sup0;
      ADDR_SUP1:     val = st.sup1;
      ADDR_EPC:      val = st.epc;
      ADDR_BADVADDR: val = st.badvaddr;
      ADDR_COUNT:    val = st.count;
      ADDR_EVEC:     val = st.evec;
      ADDR_CAUSE:    val = st.cause;
      ADDR_STATUS:   val = st.status;
      default:       val = '0;
    endcase
    return val;
  endfunction

  function automatic logic csr_mapped(input csr_addr_t addr);
    logic hit;
    case (addr)
      ADDR_SUP0, ADDR_SUP1, ADDR_EPC, ADDR_BADVADDR,
      ADDR_COUNT, ADDR_EVEC, ADDR_CAUSE, ADDR_STATUS: hit = 1'b1;
      default:                                        hit = 1'b0;
    endcase
    return hit;
  endfunction

  assign rd_data_o = csr_select(rd_addr_i, state_i);
  // live value of the checkpointed register
  assign chk_live  = csr_select(chk_addr, state_i);

  // address and data seen by the reading instruction
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      chk_addr <= rd_addr_i;
      chk_data <= rd_data_o;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      chk_valid <= 1'b0;
    end
    else if (rd_en_i)
    begin
      chk_valid <= 1'b1;
    end
    else if (flush_i || commit_i)
    begin
      chk_valid <= 1'b0;
    end
  end

  // register moved under a read that has not committed
  assign atomic_vio_o = chk_valid & csr_mapped(chk_addr) & (chk_live != chk_data);

endmodule

// ==== csr_status_unit.sv ====
/*
  status register with sret and interrupt pending
  writes are masked to bits 8..0 and IM
  IP follows irq_i with one cycle of delay, also during a write
  irq_pending_o is decoded from the registered status
*/
`timescale 1ns/1ps

module csr_status_unit
  import csr_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  csr_wr_sel_t wr_sel_i,
  input  logic        sret_i,
  input  irq_vec_t    irq_i,
  output csr_data_t   status_o,
  output logic        irq_pending_o
);

  csr_data_t status_nxt;
  irq_vec_t  irq_live;

  // write over sret over hold
  always_comb
  begin
    status_nxt = status_o;
    if (wr_sel_i.status)
    begin
      status_nxt = wr_sel_i.data & STATUS_WR_MASK;
    end
    else if (sret_i)
    begin
      // back to the previous mode and interrupt enable
      status_nxt[SR_S]  = status_o[SR_PS];
      status_nxt[SR_EI] = status_o[SR_PEI];
    end
    status_nxt[SR_IP_MSB:SR_IP_LSB] = irq_i;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      status_o <= STATUS_RESET;
    end
    else
    begin
      status_o <= status_nxt;
    end
  end

  // pending lines that are also unmasked
  assign irq_live      = status_o[SR_IP_MSB:SR_IP_LSB] & status_o[SR_IM_MSB:SR_IM_LSB];
  assign irq_pending_o = status_o[SR_EI] & (|irq_live);

endmodule

// ==== csr_trap_regs.sv ====
/*
  trap registers: epc, cause, badvaddr and evec
  an exception is captured at the next clock edge
  a committed write in the same cycle wins over the capture
  badvaddr only moves for fetch, load and store causes
*/
`timescale 1ns/1ps

module csr_trap_regs
  import csr_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  csr_wr_sel_t wr_sel_i,
  input  exc_info_t   exc_i,
  output csr_data_t   epc_o,
  output csr_data_t   cause_o,
  output csr_data_t   badvaddr_o,
  output csr_data_t   evec_o
);

  csr_data_t badvaddr_nxt;

  // pick the faulting address from the cause
  always_comb
  begin
    badvaddr_nxt = badvaddr_o;
    if (exc_i.valid)
    begin
      case (exc_i.cause)
        CAUSE_MISALIGNED_FETCH, CAUSE_FAULT_FETCH:  badvaddr_nxt = exc_i.pc;
        CAUSE_MISALIGNED_LOAD, CAUSE_FAULT_LOAD:    badvaddr_nxt = exc_i.ld_addr;
        CAUSE_MISALIGNED_STORE, CAUSE_FAULT_STORE:  badvaddr_nxt = exc_i.st_addr;
        default:                                    badvaddr_nxt = badvaddr_o;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      epc_o      <= '0;
      cause_o    <= '0;
      badvaddr_o <= '0;
      evec_o     <= '0;
    end
    else
    begin
      if (wr_sel_i.epc)
      begin
        epc_o <= wr_sel_i.data;
      end
      else if (exc_i.valid)
      begin
        epc_o <= exc_i.pc;
      end
      // cause code zero extended
      if (wr_sel_i.cause)
      begin
        cause_o <= wr_sel_i.data;
      end
      else if (exc_i.valid)
      begin
        cause_o <= csr_data_t'(exc_i.cause);
      end
      badvaddr_o <= wr_sel_i.badvaddr ? wr_sel_i.data : badvaddr_nxt;
      // trap vector is software owned
      if (wr_sel_i.evec)
      begin
        evec_o <= wr_sel_i.data;
      end
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the CSR file testbench with Verilator
set -e
verilator --binary --timing --assert -f all.f --top-module tb_sup_csr_file
./obj_dir/Vtb_sup_csr_file | tee sim.log
if grep -q "RESULT: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== sup_csr_file.sv ====
/*
  supervisor CSR file beside the retire stage
  writes are held until commit_i, a flush drops them
  reads are combinational, unmapped addresses read zero
  atomic_vio_o flags a read value that changed before the reader committed
  no back-pressure, all controls are single-cycle strobes or levels
*/
`timescale 1ns/1ps

module sup_csr_file
  import csr_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        flush_i,
  input  logic        wr_en_i,
  input  csr_addr_t   wr_addr_i,
  input  csr_data_t   wr_data_i,
  input  logic        commit_i,
  input  logic        rd_en_i,
  input  csr_addr_t   rd_addr_i,
  input  commit_cnt_t total_commit_i,
  input  exc_info_t   exc_i,
  input  logic        sret_i,
  input  irq_vec_t    irq_i,
  output csr_data_t   rd_data_o,
  output logic        atomic_vio_o,
  output logic        irq_pending_o,
  output csr_data_t   epc_o,
  output csr_data_t   evec_o,
  output csr_data_t   status_o
);

  csr_wr_sel_t wr_sel;
  csr_state_t  state;
  csr_data_t   sup0;
  csr_data_t   sup1;
  csr_data_t   badvaddr;
  csr_data_t   count;
  csr_data_t   cause;

  // write buffer and strobe decode
  csr_commit_ctrl u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .flush_i   (flush_i),
    .wr_en_i   (wr_en_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .commit_i  (commit_i),
    .wr_sel_o  (wr_sel)
  );

  // epc, cause, badvaddr and evec
  csr_trap_regs u_trap (
    .clk        (clk),
    .reset      (reset),
    .wr_sel_i   (wr_sel),
    .exc_i      (exc_i),
    .epc_o      (epc_o),
    .cause_o    (cause),
    .badvaddr_o (badvaddr),
    .evec_o     (evec_o)
  );

  csr_status_unit u_status (
    .clk           (clk),
    .reset         (reset),
    .wr_sel_i      (wr_sel),
    .sret_i        (sret_i),
    .irq_i         (irq_i),
    .status_o      (status_o),
    .irq_pending_o (irq_pending_o)
  );

  csr_count_scratch u_count (
    .clk            (clk),
    .reset          (reset),
    .wr_sel_i       (wr_sel),
    .total_commit_i (total_commit_i),
    .exc_i          (exc_i),
    .count_o        (count),
    .sup0_o         (sup0),
    .sup1_o         (sup1)
  );

  // gather the live registers for the read side
  assign state = '{
    sup0:     sup0,
    sup1:     sup1,
    epc:      epc_o,
    badvaddr: badvaddr,
    count:    count,
    evec:     evec_o,
    cause:    cause,
    status:   status_o
  };

  csr_read_port u_read (
    .clk          (clk),
    .reset        (reset),
    .flush_i      (flush_i),
    .commit_i     (commit_i),
    .rd_en_i      (rd_en_i),
    .rd_addr_i    (rd_addr_i),
    .state_i      (state),
    .rd_data_o    (rd_data_o),
    .atomic_vio_o (atomic_vio_o)
  );

endmodule

// ==== sup_csr_file_chk.sv ====
/*
  assertions on the CSR file flags, attached to every sup_csr_file by bind
  IP is expected to trail irq_i by exactly one cycle
*/
`timescale 1ns/1ps

module sup_csr_file_chk
  import csr_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      flush_i,
  input logic      rd_en_i,
  input irq_vec_t  irq_i,
  input logic      atomic_vio_o,
  input logic      irq_pending_o,
  input csr_data_t status_o
);

  // flags come out of reset low
  reset_flags_low: assert property (@(posedge clk) $fell(reset) |-> !atomic_vio_o && !irq_pending_o)
    else $error("flags not low after reset");

  // a flush without a new read drops the checkpoint
  flush_clears_vio: assert property (@(posedge clk) disable iff (reset)
    (flush_i && !rd_en_i) |=> !atomic_vio_o)
    else $error("atomic violation still high after flush");

  ip_follows_irq: assert property (@(posedge clk) disable iff (reset)
    status_o[SR_IP_MSB:SR_IP_LSB] == $past(irq_i))
    else $error("status IP does not follow irq_i");

endmodule

bind sup_csr_file sup_csr_file_chk u_chk (.*);

// ==== tb_sup_csr_file.sv ====
/*
  testbench of the supervisor CSR file
  operations and expected values come from csr_input.txt, run from the project root
  inputs change on the falling edge, outputs are sampled just before the next one
  the first mismatch ends the run
*/
`timescale 1ns/1ps

module tb_sup_csr_file
  import csr_pkg::*;
();

  localparam int HALF_PERIOD  = 20;
  localparam int CLK_PERIOD   = 2 * HALF_PERIOD;
  localparam int RESET_CYCLES = 16;

  // one line of the data file
  typedef struct packed {
    logic [3:0] op;
    csr_addr_t  addr;
    csr_data_t  data;
    csr_data_t  aux;
    csr_data_t  result;
  } op_rec_t;

  logic        clk;
  logic        reset;
  logic        flush_i;
  logic        wr_en_i;
  csr_addr_t   wr_addr_i;
  csr_data_t   wr_data_i;
  logic        commit_i;
  logic        rd_en_i;
  csr_addr_t   rd_addr_i;
  commit_cnt_t total_commit_i;
  exc_info_t   exc_i;
  logic        sret_i;
  irq_vec_t    irq_i;
  csr_data_t   rd_data_o;
  logic        atomic_vio_o;
  logic        irq_pending_o;
  csr_data_t   epc_o;
  csr_data_t   evec_o;
  csr_data_t   status_o;

  op_rec_t     ops[$];
  logic        ops_loaded;
  int unsigned timeout_ns;
  int          seed;
  csr_data_t   got_data;
  logic        got_vio;
  logic        got_pend;
  csr_data_t   got_epc;
  csr_data_t   got_evec;
  csr_data_t   got_status;

  sup_csr_file u_dut (
    .clk            (clk),
    .reset          (reset),
    .flush_i        (flush_i),
    .wr_en_i        (wr_en_i),
    .wr_addr_i      (wr_addr_i),
    .wr_data_i      (wr_data_i),
    .commit_i       (commit_i),
    .rd_en_i        (rd_en_i),
    .rd_addr_i      (rd_addr_i),
    .total_commit_i (total_commit_i),
    .exc_i          (exc_i),
    .sret_i         (sret_i),
    .irq_i          (irq_i),
    .rd_data_o      (rd_data_o),
    .atomic_vio_o   (atomic_vio_o),
    .irq_pending_o  (irq_pending_o),
    .epc_o          (epc_o),
    .evec_o         (evec_o),
    .status_o       (status_o)
  );

  always #(HALF_PERIOD) clk = ~clk;

  task automatic check_value(input string name, input csr_data_t exp_val,
                             input csr_data_t act_val);
    if (exp_val !== act_val)
    begin
      $display("** Error %s: expected %h, actual %h", name, exp_val, act_val);
      $display("RESULT: FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // called just after a falling edge, returns just after the next one
  task automatic sample_outputs();
    @(posedge clk);
    #(HALF_PERIOD - 2);
    got_data   = rd_data_o;
    got_vio    = atomic_vio_o;
    got_pend   = irq_pending_o;
    got_epc    = epc_o;
    got_evec   = evec_o;
    got_status = status_o;
    @(negedge clk);
  endtask

  // epc, evec and status also leave the DUT on their own ports
  task automatic check_direct_outputs(input string tag, input csr_addr_t addr,
                                      input csr_data_t exp_val);
    case (addr)
      ADDR_EPC:    check_value({tag, " epc_o"}, exp_val, got_epc);
      ADDR_EVEC:   check_value({tag, " evec_o"}, exp_val, got_evec);
      ADDR_STATUS: check_value({tag, " status_o"}, exp_val, got_status);
      default:     ;
    endcase
  endtask

  task automatic read_csr(input csr_addr_t addr);
    rd_addr_i = addr;
    sample_outputs();
  endtask

  task automatic drive_exception(input op_rec_t rec);
    exc_i.valid   = 1'b1;
    exc_i.pc      = rec.data;
    exc_i.cause   = rec.addr[3:0];
    // the address that the cause does not select gets noise
    exc_i.ld_addr = {$random(seed), $random(seed)};
    exc_i.st_addr = {$random(seed), $random(seed)};
    if (rec.addr[3:0] inside {CAUSE_MISALIGNED_LOAD, CAUSE_FAULT_LOAD})
    begin
      exc_i.ld_addr = rec.aux;
    end
    if (rec.addr[3:0] inside {CAUSE_MISALIGNED_STORE, CAUSE_FAULT_STORE})
    begin
      exc_i.st_addr = rec.aux;
    end
    @(negedge clk);
    exc_i = '0;
  endtask

  task automatic run_op(input op_rec_t rec, input int idx);
    string     tag;
    csr_data_t cnt_before;
    tag = $sformatf("op %0d", idx);
    case (rec.op)
      4'h0:
      begin
        read_csr(rec.addr);
        check_value({tag, " read"}, rec.result, got_data);
        check_direct_outputs(tag, rec.addr, rec.result);
      end
      4'h1, 4'h2:
      begin
        wr_en_i   = 1'b1;
        wr_addr_i = rec.addr;
        wr_data_i = rec.data;
        @(negedge clk);
        wr_en_i = 1'b0;
        // op 2 squashes the buffered write before it commits
        if (rec.op == 4'h2)
        begin
          flush_i = 1'b1;
          @(negedge clk);
          flush_i = 1'b0;
        end
        commit_i = 1'b1;
        @(negedge clk);
        commit_i = 1'b0;
        read_csr(rec.addr);
        check_value({tag, " readback"}, rec.result, got_data);
        check_direct_outputs(tag, rec.addr, rec.result);
      end
      4'h3:
      begin
        read_csr(ADDR_COUNT);
        cnt_before = got_data;
        drive_exception(rec);
        read_csr(ADDR_EPC);
        check_value({tag, " epc"}, rec.data, got_data);
        check_direct_outputs(tag, ADDR_EPC, rec.data);
        read_csr(ADDR_CAUSE);
        check_value({tag, " cause"}, csr_data_t'(rec.addr[3:0]), got_data);
        read_csr(ADDR_BADVADDR);
        check_value({tag, " badvaddr"}, rec.result, got_data);
        // the excepting instruction counts as retired
        read_csr(ADDR_COUNT);
        check_value({tag, " count"}, cnt_before + 64'd1, got_data);
      end
      4'h4:
      begin
        sret_i = 1'b1;
        @(negedge clk);
        sret_i = 1'b0;
        read_csr(rec.addr);
        check_value({tag, " status after sret"}, rec.result, got_data);
        check_direct_outputs(tag, rec.addr, rec.result);
      end
      4'h5:
      begin
        total_commit_i = rec.data[2:0];
        @(negedge clk);
        total_commit_i = '0;
        read_csr(rec.addr);
        check_value({tag, " count"}, rec.result, got_data);
      end
      4'h6:
      begin
        // irq_i stays at this level until the next irq op
        irq_i = rec.data[7:0];
        @(negedge clk);
        read_csr(rec.addr);
        check_value({tag, " irq pending"}, rec.result, csr_data_t'(got_pend));
        check_value({tag, " status"}, rec.aux, got_data);
        check_direct_outputs(tag, rec.addr, rec.aux);
      end
      4'h7:
      begin
        rd_en_i   = 1'b1;
        rd_addr_i = rec.addr;
        @(negedge clk);
        rd_en_i        = 1'b0;
        total_commit_i = rec.data[2:0];
        @(negedge clk);
        total_commit_i = '0;
        sample_outputs();
        check_value({tag, " violation"}, rec.result, csr_data_t'(got_vio));
        commit_i = 1'b1;
        @(negedge clk);
        commit_i = 1'b0;
        sample_outputs();
        check_value({tag, " violation after commit"}, rec.aux, csr_data_t'(got_vio));
      end
      default:
      begin
        $display("%s has an unknown operation code %h", tag, rec.op);
        $display("RESULT: FAIL");
        $fatal(1, "bad operation code");
      end
    endcase
  endtask

  initial
  begin : watchdog
    wait (ops_loaded === 1'b1);
    #(timeout_ns);
    $display("the run timed out before all operations finished");
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

  initial
  begin : main
    int         fd;
    int         rc;
    int         n;
    string      line;
    logic [3:0] f_op;
    csr_addr_t  f_addr;
    csr_data_t  f_data;
    csr_data_t  f_aux;
    csr_data_t  f_result;
    op_rec_t    rec;
    clk            = 1'b0;
    reset          = 1'b1;
    flush_i        = 1'b0;
    wr_en_i        = 1'b0;
    wr_addr_i      = '0;
    wr_data_i      = '0;
    commit_i       = 1'b0;
    rd_en_i        = 1'b0;
    rd_addr_i      = '0;
    total_commit_i = '0;
    exc_i          = '0;
    sret_i         = 1'b0;
    irq_i          = '0;
    ops_loaded     = 1'b0;
    seed           = 42706;
    fd = $fopen("csr_input.txt", "r");
    if (fd == 0)
    begin
      $display("could not open csr_input.txt");
      $display("RESULT: FAIL");
      $fatal(1, "missing data file");
    end
    while ($feof(fd) == 0)
    begin
      line = "";
      rc   = $fgets(line, fd);
      // skip comment lines
      if (rc > 0 && !(line.len() >= 2 && line.substr(0, 1) == "//"))
      begin
        n = $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_data, f_aux, f_result);
        if (n == 5)
        begin
          rec.op     = f_op;
          rec.addr   = f_addr;
          rec.data   = f_data;
          rec.aux    = f_aux;
          rec.result = f_result;
          ops.push_back(rec);
        end
        else if (n > 0)
        begin
          $display("malformed line in csr_input.txt: %s", line);
          $display("RESULT: FAIL");
          $fatal(1, "bad data file");
        end
      end
    end
    $fclose(fd);
    if (ops.size() == 0)
    begin
      $display("csr_input.txt holds no operations");
      $display("RESULT: FAIL");
      $fatal(1, "empty data file");
    end
    timeout_ns = ops.size() * 4 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
    ops_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    foreach (ops[i])
    begin
      run_op(ops[i], i);
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule
